/* source/sgd_pkg.sv */
// SGD engine shared definitions
// sizes, the batch entry carried through the FIFO and the FSM state types

`default_nettype none

package sgd_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    localparam int NUM_FEATURES = 8;
    localparam int FEATURE_W    = 8;
    localparam int B_W          = 16;
    // model word, gradient and dot product share one width
    localparam int MODEL_W      = 32;
    localparam int FEAT_IDX_W   = 3;
    // samples per model update, also the FIFO depth
    localparam int MINI_BATCH   = 4;
    localparam int SHIFT_W      = 4;
    localparam int CNT_W        = 16;

    ////////////////////////////////////////////////////////////
    // data types
    // one sample, feature 0 in the low byte
    typedef logic [NUM_FEATURES-1:0][FEATURE_W-1:0] sample_vec_t;

    // 64 + 16 + 32 = 112 bits
    typedef struct packed {
        sample_vec_t               a;
        logic signed [B_W-1:0]     b;
        logic signed [MODEL_W-1:0] dot;
    } batch_entry_t;

    // producer states
    typedef enum logic [1:0] {DOT_IDLE, DOT_MAC, DOT_PUSH, DOT_WAIT_UPDATE} dot_state_t;

    // consumer states
    typedef enum logic [2:0] {
        UPD_IDLE, UPD_LOSS, UPD_ACCUMULATE, UPD_WRITE_MODEL, UPD_FINISH
    } upd_state_t;

endpackage

`default_nettype wire

/* source/sgd_sample_if.sv */
// batch entry channel
// producer pushes entries, the FIFO holds them, the consumer pops the head

`timescale 1ns/1ps
`default_nettype none

interface sgd_sample_if;
    import sgd_pkg::*;

    // push side
    logic         wr_en;
    batch_entry_t entry;
    logic         full;

    // pop side, head is valid while valid is high
    logic         valid;
    batch_entry_t head;
    logic         rd_en;

    modport push (
        output wr_en,
        output entry,
        input  full
    );

    modport pop (
        input  valid,
        input  head,
        output rd_en
    );

    modport fifo (
        input  wr_en,
        input  entry,
        output full,
        output valid,
        output head,
        input  rd_en
    );

endinterface

`default_nettype wire

/* source/sgd_model_if.sv */
// model store access
// combinational read for the dot product, read-modify-write port for the update

`timescale 1ns/1ps
`default_nettype none

interface sgd_model_if;
    import sgd_pkg::*;

    // producer read
    logic        [FEAT_IDX_W-1:0] rd_addr;
    logic signed [MODEL_W-1:0]    rd_data;

    // consumer write, old_data is the current word at wr_addr
    logic                         wr_en;
    logic        [FEAT_IDX_W-1:0] wr_addr;
    logic signed [MODEL_W-1:0]    wr_data;
    logic signed [MODEL_W-1:0]    old_data;

    modport reader (output rd_addr, input rd_data);

    modport writer (output wr_en, output wr_addr, output wr_data, input old_data);

    modport store (
        input  rd_addr,
        output rd_data,
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        output old_data
    );

endinterface

`default_nettype wire

/* source/sgd_dot_product.sv */
// SGD producer
// takes one labelled sample, computes its dot product with the model one
// feature per cycle and pushes sample, label and dot product into the FIFO;
// after every mini-batch it waits for the model update to be written

`timescale 1ns/1ps
`default_nettype none

module sgd_dot_product (
    input  wire                        clk,
    input  wire                        rst_n_g,
    input  wire                        run_start,
    input  sgd_pkg::sample_vec_t       sample_a,
    input  wire signed [sgd_pkg::B_W-1:0] sample_b,
    input  wire                        sample_wr_en,
    output logic                       sample_almost_full,
    input  wire                        batch_updated,
    sgd_sample_if.push                 buf_if,
    sgd_model_if.reader                model
);
    import sgd_pkg::*;

    dot_state_t                    state;
    logic [FEAT_IDX_W-1:0]         feat_idx;
    logic [$clog2(MINI_BATCH)-1:0] push_cnt;
    sample_vec_t                   sample_r;
    logic signed [B_W-1:0]         label_r;
    logic signed [MODEL_W-1:0]     acc;
    logic                          accept;
    logic                          last_feat;

    // only idle takes a sample
    assign sample_almost_full = (state != DOT_IDLE);
    assign accept    = (state == DOT_IDLE) && sample_wr_en;
    assign last_feat = (feat_idx == FEAT_IDX_W'(NUM_FEATURES - 1));

    assign model.rd_addr = feat_idx;

    assign buf_if.wr_en = (state == DOT_PUSH) && !buf_if.full;
    assign buf_if.entry = '{a: sample_r, b: label_r, dot: acc};

    ////////////////////////////////////////////////////////////
    // control
    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            state    <= DOT_IDLE;
            feat_idx <= '0;
            push_cnt <= '0;
        end
        else
        begin
            if (run_start)
                push_cnt <= '0;
            case (state)
                DOT_IDLE:
                begin
                    feat_idx <= '0;
                    if (accept)
                        state <= DOT_MAC;
                end
                DOT_MAC:
                begin
                    feat_idx <= feat_idx + 1'b1;
                    if (last_feat)
                        state <= DOT_PUSH;
                end
                // hold here while the FIFO is full
                DOT_PUSH:
                begin
                    if (buf_if.wr_en)
                    begin
                        push_cnt <= push_cnt + 1'b1;
                        if (32'(push_cnt) == MINI_BATCH - 1)
                            state <= DOT_WAIT_UPDATE;
                        else
                            state <= DOT_IDLE;
                    end
                end
                // RAW guard, next batch reads the updated model
                DOT_WAIT_UPDATE:
                begin
                    if (batch_updated)
                        state <= DOT_IDLE;
                end
                default: state <= DOT_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // datapath
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            sample_r <= sample_a;
            label_r  <= sample_b;
            acc      <= '0;
        end
        else if (state == DOT_MAC)
            // wraps at MODEL_W bits
            acc <= acc + model.rd_data * $signed(sample_r[feat_idx]);
    end

endmodule

`default_nettype wire

/* source/sgd_batch_fifo.sv */
// mini-batch FIFO
// circular buffer of MINI_BATCH entries between producer and consumer,
// head visible one cycle after its push

`timescale 1ns/1ps
`default_nettype none

module sgd_batch_fifo (
    input  wire      clk,
    input  wire      rst_n_g,
    sgd_sample_if.fifo port
);
    import sgd_pkg::*;

    batch_entry_t                    mem [MINI_BATCH];
    logic [$clog2(MINI_BATCH)-1:0]   wr_ptr;
    logic [$clog2(MINI_BATCH)-1:0]   rd_ptr;
    logic [$clog2(MINI_BATCH+1)-1:0] count;
    logic                            push;
    logic                            pop;

    assign port.full  = (32'(count) == MINI_BATCH);
    assign port.valid = (count != '0);
    assign port.head  = mem[rd_ptr];

    // guard against a push when full or a pop when empty
    assign push = port.wr_en && !port.full;
    assign pop  = port.rd_en && port.valid;

    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (32'(wr_ptr) == MINI_BATCH - 1) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (32'(rd_ptr) == MINI_BATCH - 1) ? '0 : rd_ptr + 1'b1;
            // push and pop together leave count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= port.entry;
    end

endmodule

`default_nettype wire

/* source/sgd_gradient_update.sv */
// SGD consumer
// pops entries, forms the shifted loss and accumulates the gradient;
// after a mini-batch writes x - grad back to the model store,
// pulses batch_updated and counts batches to raise done

`timescale 1ns/1ps
`default_nettype none

module sgd_gradient_update (
    input  wire                        clk,
    input  wire                        rst_n_g,
    input  wire                        run_start,
    input  wire [sgd_pkg::CNT_W-1:0]   number_of_samples,
    input  wire [sgd_pkg::CNT_W-1:0]   number_of_epochs,
    input  wire [sgd_pkg::SHIFT_W-1:0] step_shift,
    output logic                       batch_updated,
    output logic                       done,
    sgd_sample_if.pop                  buf_if,
    sgd_model_if.writer                model
);
    import sgd_pkg::*;

    upd_state_t                    state;
    batch_entry_t                  entry_r;
    logic signed [MODEL_W-1:0]     loss;
    logic signed [MODEL_W-1:0]     grad [NUM_FEATURES];
    logic [FEAT_IDX_W-1:0]         feat_idx;
    logic [$clog2(MINI_BATCH)-1:0] entry_cnt;
    logic [2*CNT_W-1:0]            batch_cnt;
    logic [2*CNT_W-1:0]            total_batches;
    logic                          running;
    logic                          last_feat;

    assign last_feat = (feat_idx == FEAT_IDX_W'(NUM_FEATURES - 1));

    // batches per epoch times epochs
    assign total_batches = (2*CNT_W)'(number_of_samples / MINI_BATCH) *
                           (2*CNT_W)'(number_of_epochs);

    // pop only inside a run
    assign buf_if.rd_en = (state == UPD_IDLE) && running && buf_if.valid;

    // read-modify-write, old word comes back combinationally
    assign model.wr_en   = (state == UPD_WRITE_MODEL);
    assign model.wr_addr = feat_idx;
    assign model.wr_data = model.old_data - grad[feat_idx];

    ////////////////////////////////////////////////////////////
    // control
    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            state         <= UPD_IDLE;
            feat_idx      <= '0;
            entry_cnt     <= '0;
            batch_cnt     <= '0;
            running       <= 1'b0;
            done          <= 1'b0;
            batch_updated <= 1'b0;
        end
        else
        begin
            batch_updated <= 1'b0;
            if (run_start)
            begin
                running   <= 1'b1;
                done      <= 1'b0;
                batch_cnt <= '0;
                entry_cnt <= '0;
            end
            case (state)
                UPD_IDLE:
                begin
                    if (buf_if.rd_en)
                        state <= UPD_LOSS;
                end
                UPD_LOSS:
                begin
                    feat_idx <= '0;
                    state    <= UPD_ACCUMULATE;
                end
                UPD_ACCUMULATE:
                begin
                    feat_idx <= feat_idx + 1'b1;
                    if (last_feat)
                    begin
                        if (32'(entry_cnt) == MINI_BATCH - 1)
                        begin
                            entry_cnt <= '0;
                            state     <= UPD_WRITE_MODEL;
                        end
                        else
                        begin
                            entry_cnt <= entry_cnt + 1'b1;
                            state     <= UPD_IDLE;
                        end
                    end
                end
                UPD_WRITE_MODEL:
                begin
                    feat_idx <= feat_idx + 1'b1;
                    if (last_feat)
                    begin
                        // releases the producer
                        batch_updated <= 1'b1;
                        batch_cnt     <= batch_cnt + 1'b1;
                        state         <= UPD_FINISH;
                        if (batch_cnt + 1'b1 == total_batches)
                        begin
                            done    <= 1'b1;
                            running <= 1'b0;
                        end
                    end
                end
                UPD_FINISH: state <= UPD_IDLE;
                default:    state <= UPD_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // datapath
    always_ff @(posedge clk)
    begin
        if (run_start)
        begin
            for (int j = 0; j < NUM_FEATURES; j++)
                grad[j] <= '0;
        end
        case (state)
            UPD_IDLE:
                if (buf_if.rd_en)
                    entry_r <= buf_if.head;
            // arithmetic shift keeps the sign
            UPD_LOSS:
                loss <= (entry_r.dot - entry_r.b) >>> step_shift;
            UPD_ACCUMULATE:
                grad[feat_idx] <= grad[feat_idx] + loss * $signed(entry_r.a[feat_idx]);
            // cleared as it is consumed
            UPD_WRITE_MODEL:
                grad[feat_idx] <= '0;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* source/sgd_model_store.sv */
// model store
// NUM_FEATURES model words, zero after reset; combinational read for the
// dot product, read-modify-write for the update, registered readback

`timescale 1ns/1ps
`default_nettype none

module sgd_model_store (
    input  wire                                clk,
    input  wire                                rst_n_g,
    input  wire [sgd_pkg::FEAT_IDX_W-1:0]      x_rd_addr,
    output logic signed [sgd_pkg::MODEL_W-1:0] x_rd_data,
    sgd_model_if.store                         port
);
    import sgd_pkg::*;

    logic signed [MODEL_W-1:0] x [NUM_FEATURES];

    // engine reads
    assign port.rd_data  = x[port.rd_addr];
    assign port.old_data = x[port.wr_addr];

    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            for (int j = 0; j < NUM_FEATURES; j++)
                x[j] <= '0;
        end
        else if (port.wr_en)
            x[port.wr_addr] <= port.wr_data;
    end

    // readback, one cycle after the address
    always_ff @(posedge clk)
    begin
        x_rd_data <= x[x_rd_addr];
    end

endmodule

`default_nettype wire

/* source/sgd_top.sv */
// SGD engine top level
// latches the run configuration on start, issues the run_start pulse and
// connects producer, mini-batch FIFO, consumer and model store

`timescale 1ns/1ps
`default_nettype none

module sgd_top (
    input  wire                                clk,
    input  wire                                rst_n_g,
    input  wire                                start,
    input  wire [sgd_pkg::CNT_W-1:0]           number_of_samples,
    input  wire [sgd_pkg::CNT_W-1:0]           number_of_epochs,
    input  wire [sgd_pkg::SHIFT_W-1:0]         step_shift,
    input  sgd_pkg::sample_vec_t               sample_a,
    input  wire signed [sgd_pkg::B_W-1:0]      sample_b,
    input  wire                                sample_wr_en,
    output logic                               sample_almost_full,
    output logic                               done,
    input  wire [sgd_pkg::FEAT_IDX_W-1:0]      x_rd_addr,
    output logic signed [sgd_pkg::MODEL_W-1:0] x_rd_data
);
    import sgd_pkg::*;

    logic               busy;
    logic               run_start;
    logic               start_accept;
    logic               batch_updated;
    logic [CNT_W-1:0]   samples_r;
    logic [CNT_W-1:0]   epochs_r;
    logic [SHIFT_W-1:0] shift_r;

    sgd_sample_if sample_bus ();
    sgd_model_if  model_bus ();

    ////////////////////////////////////////////////////////////
    // run control
    // start counts only while idle, after reset or after done
    assign start_accept = start && !busy;

    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            busy      <= 1'b0;
            run_start <= 1'b0;
        end
        else
        begin
            run_start <= start_accept;
            // done is still high during run_start, skip that cycle
            if (start_accept)
                busy <= 1'b1;
            else if (done && !run_start)
                busy <= 1'b0;
        end
    end

    // run configuration
    always_ff @(posedge clk)
    begin
        if (start_accept)
        begin
            samples_r <= number_of_samples;
            epochs_r  <= number_of_epochs;
            shift_r   <= step_shift;
        end
    end

    ////////////////////////////////////////////////////////////
    // engine
    sgd_dot_product dot_product_i (
        .clk                (clk),
        .rst_n_g            (rst_n_g),
        .run_start          (run_start),
        .sample_a           (sample_a),
        .sample_b           (sample_b),
        .sample_wr_en       (sample_wr_en),
        .sample_almost_full (sample_almost_full),
        .batch_updated      (batch_updated),
        .buf_if             (sample_bus.push),
        .model              (model_bus.reader)
    );

    sgd_batch_fifo batch_fifo_i (
        .clk     (clk),
        .rst_n_g (rst_n_g),
        .port    (sample_bus.fifo)
    );

    sgd_gradient_update gradient_update_i (
        .clk               (clk),
        .rst_n_g           (rst_n_g),
        .run_start         (run_start),
        .number_of_samples (samples_r),
        .number_of_epochs  (epochs_r),
        .step_shift        (shift_r),
        .batch_updated     (batch_updated),
        .done              (done),
        .buf_if            (sample_bus.pop),
        .model             (model_bus.writer)
    );

    sgd_model_store model_store_i (
        .clk       (clk),
        .rst_n_g   (rst_n_g),
        .x_rd_addr (x_rd_addr),
        .x_rd_data (x_rd_data),
        .port      (model_bus.store)
    );

endmodule

`default_nettype wire

/* testbench/sgd_top_assertions.sv */
// SGD engine bound checks
// sample handshake, done hold behavior, reset state and readback stability

`timescale 1ns/1ps
`default_nettype none

module sgd_top_assertions (
    input wire                                clk,
    input wire                                rst_n_g,
    input wire                                start,
    input wire                                sample_wr_en,
    input wire                                sample_almost_full,
    input wire                                done,
    input wire [sgd_pkg::FEAT_IDX_W-1:0]      x_rd_addr,
    input wire signed [sgd_pkg::MODEL_W-1:0]  x_rd_data
);
    // failures seen so far, read by the testbench
    int unsigned fail_count = 0;

    ////////////////////////////////////////////////////////////
    // outputs right after reset
    reset_state_a: assert property (@(posedge clk)
        $rose(rst_n_g) |-> !done && !sample_almost_full)
    else
    begin
        $error("done or sample_almost_full high right after reset");
        fail_count++;
    end

    // source must respect back-pressure
    no_push_when_full_a: assert property (@(posedge clk) disable iff (!rst_n_g)
        !(sample_wr_en && sample_almost_full))
    else
    begin
        $error("sample pushed while sample_almost_full was high");
        fail_count++;
    end

    // done only drops two cycles after an accepted start
    done_held_a: assert property (@(posedge clk) disable iff (!rst_n_g)
        $fell(done) |-> $past(start, 2))
    else
    begin
        $error("done dropped without a start");
        fail_count++;
    end

    // model frozen after done, so a held address gives a held word
    readback_stable_a: assert property (@(posedge clk) disable iff (!rst_n_g)
        done && $past(done) && $stable(x_rd_addr) |=> $stable(x_rd_data))
    else
    begin
        $error("x_rd_data changed while the address was held after done");
        fail_count++;
    end

endmodule

bind sgd_top sgd_top_assertions assertions_i (.*);

`default_nettype wire

/* testbench/tb_sgd_top.sv */
// SGD engine testbench
// drives labelled samples through several runs, keeps a golden mini-batch
// model alongside and compares the read-back model after each done

`timescale 1ns/1ps
`default_nettype none

module tb_sgd_top;
    import sgd_pkg::*;

    // 4 + 3 x 8 + 2 x 4 samples over all runs
    localparam int TIMEOUT_CYCLES = 40 * (4 + 3 * 8 + 2 * 4) + 1000;

    logic                      clk;
    logic                      rst_n_g;
    logic                      start;
    logic [CNT_W-1:0]          number_of_samples;
    logic [CNT_W-1:0]          number_of_epochs;
    logic [SHIFT_W-1:0]        step_shift;
    sample_vec_t               sample_a;
    logic signed [B_W-1:0]     sample_b;
    logic                      sample_wr_en;
    logic                      sample_almost_full;
    logic                      done;
    logic [FEAT_IDX_W-1:0]     x_rd_addr;
    logic signed [MODEL_W-1:0] x_rd_data;

    // samples of the current run and the golden model
    sample_vec_t sa [8];
    shortint     sb [8];
    int          gx [NUM_FEATURES];
    int          errors;
    int          tests;
    int          failed_tests;
    int          cycles;

    sgd_top sgd_top_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int feature_value(input sample_vec_t v, input int j);
        feature_value = int'(byte'(v[j]));
    endfunction

    ////////////////////////////////////////////////////////////
    // golden model, one mini-batch starting at sample first
    task automatic golden_batch(input int first, input int shift);
        int s;
        int j;
        int dot;
        int loss;
        int grad [NUM_FEATURES];
        begin
            for (j = 0; j < NUM_FEATURES; j++)
                grad[j] = 0;
            for (s = first; s < first + MINI_BATCH; s++)
            begin
                // every dot product of a batch sees the model before the update
                dot = 0;
                for (j = 0; j < NUM_FEATURES; j++)
                    dot += gx[j] * feature_value(sa[s], j);
                loss = (dot - int'(sb[s])) >>> shift;
                for (j = 0; j < NUM_FEATURES; j++)
                    grad[j] += loss * feature_value(sa[s], j);
            end
            for (j = 0; j < NUM_FEATURES; j++)
                gx[j] -= grad[j];
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus, every task starts and ends 1 ns after an edge
    task automatic push_sample(input sample_vec_t a, input shortint b);
        begin
            while (sample_almost_full)
            begin
                @(posedge clk);
                #1;
            end
            sample_a     = a;
            sample_b     = b;
            sample_wr_en = 1'b1;
            @(posedge clk);
            #1;
            sample_wr_en = 1'b0;
        end
    endtask

    // registered readback, word valid one edge after the address
    task automatic check_model();
        int j;
        begin
            for (j = 0; j < NUM_FEATURES; j++)
            begin
                x_rd_addr = FEAT_IDX_W'(j);
                @(posedge clk);
                #1;
                assert (x_rd_data === gx[j])
                else
                begin
                    $display("ERR x_rd_data[%0d] expected %h got %h", j, gx[j], x_rd_data);
                    errors++;
                end
            end
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        begin
            tests++;
            if (errors != err_before)
            begin
                failed_tests++;
                $display("test %s: failed with %0d errors", name, errors - err_before);
            end
            else
                $display("test %s: passed", name);
        end
    endtask

    task automatic fill_fixed();
        int i;
        int j;
        begin
            for (i = 0; i < MINI_BATCH; i++)
            begin
                for (j = 0; j < NUM_FEATURES; j++)
                    sa[i][j] = 8'(3 * i - j + 2);
                sb[i] = shortint'(25 * i - 40);
            end
        end
    endtask

    // small features keep the products readable
    task automatic fill_random(input int n);
        int i;
        int j;
        begin
            for (i = 0; i < n; i++)
            begin
                for (j = 0; j < NUM_FEATURES; j++)
                    sa[i][j] = 8'(int'($urandom_range(6)) - 3);
                sb[i] = shortint'(int'($urandom_range(200)) - 100);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one run: start, all epochs of pushes, wait for done, readback
    task automatic run_training(input string name, input int n_samples,
                                input int n_epochs, input int shift);
        int e;
        int bt;
        int s;
        int pushed;
        int err_before;
        begin
            err_before        = errors;
            pushed            = 0;
            number_of_samples = CNT_W'(n_samples);
            number_of_epochs  = CNT_W'(n_epochs);
            step_shift        = SHIFT_W'(shift);
            start             = 1'b1;
            @(posedge clk);
            #1;
            start = 1'b0;
            // done clears on the run_start edge
            @(posedge clk);
            #1;
            for (e = 0; e < n_epochs; e++)
            begin
                for (bt = 0; bt < n_samples; bt += MINI_BATCH)
                begin
                    for (s = bt; s < bt + MINI_BATCH; s++)
                    begin
                        assert (!done)
                        else
                        begin
                            $display("done rose after only %0d of %0d samples",
                                     pushed, n_samples * n_epochs);
                            errors++;
                        end
                        push_sample(sa[s], sb[s]);
                        pushed++;
                    end
                    golden_batch(bt, shift);
                end
            end
            while (!done)
            begin
                @(posedge clk);
                #1;
            end
            check_model();
            report_test(name, err_before);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    initial
    begin
        int err_before;
        rst_n_g           = 1'b0;
        start             = 1'b0;
        number_of_samples = '0;
        number_of_epochs  = '0;
        step_shift        = '0;
        sample_a          = '0;
        sample_b          = '0;
        sample_wr_en      = 1'b0;
        x_rd_addr         = '0;
        errors            = 0;
        tests             = 0;
        failed_tests      = 0;
        void'($urandom(7));
        for (int j = 0; j < NUM_FEATURES; j++)
            gx[j] = 0;
        repeat (16) @(posedge clk);
        #1;
        rst_n_g = 1'b1;

        // model cleared, outputs quiet
        err_before = errors;
        assert (!done && !sample_almost_full)
        else
        begin
            $display("done or sample_almost_full high after reset");
            errors++;
        end
        check_model();
        report_test("reset_state", err_before);

        fill_fixed();
        run_training("single_batch", 4, 1, 0);
        // several batches, credit wait between them
        fill_random(8);
        run_training("multi_epoch", 8, 3, 3);
        // continues from the trained model
        fill_random(4);
        run_training("resume_run", 4, 2, 1);

        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests, failed_tests, errors, sgd_top_i.assertions_i.fail_count);
        if (errors == 0 && sgd_top_i.assertions_i.fail_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // run limit
    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, done never came", cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
source/sgd_pkg.sv
source/sgd_sample_if.sv
source/sgd_model_if.sv
source/sgd_dot_product.sv
source/sgd_batch_fifo.sv
source/sgd_gradient_update.sv
source/sgd_model_store.sv
source/sgd_top.sv
testbench/sgd_top_assertions.sv
testbench/tb_sgd_top.sv
